/* include/f8_exec_config.svh */
`ifndef F8_EXEC_CONFIG_SVH
`define F8_EXEC_CONFIG_SVH

`define F8_BYTE_W 8
`define F8_WORD_W 16
`define F8_INST_W 24

// x, y and z
`define F8_NUM_REGS 3

`define F8_RESET_PC 16'h4000

`define F8_FLAG_W 5

`endif

/* logic/f8_exec_pkg.sv */
`include "f8_exec_config.svh"

package f8_exec_pkg;

	typedef enum logic [`F8_BYTE_W-1:0]
	{
		OPCODE_NOP = 8'h00,
		// 8-bit immediate forms
		OPCODE_ADD_XL_IMMD = 8'h10,
		OPCODE_ADC_XL_IMMD = 8'h11,
		OPCODE_SUB_XL_IMMD = 8'h12,
		OPCODE_SBC_XL_IMMD = 8'h13,
		OPCODE_AND_XL_IMMD = 8'h14,
		OPCODE_OR_XL_IMMD = 8'h15,
		OPCODE_XOR_XL_IMMD = 8'h16,
		OPCODE_CP_XL_IMMD = 8'h17,
		// one-byte unary forms
		OPCODE_INC_XL = 8'h20,
		OPCODE_DEC_XL = 8'h21,
		OPCODE_CLR_XL = 8'h22,
		OPCODE_TST_XL = 8'h23,
		OPCODE_SRL_XL = 8'h24,
		OPCODE_SLL_XL = 8'h25,
		OPCODE_RRC_XL = 8'h26,
		OPCODE_RLC_XL = 8'h27,
		OPCODE_LDW_Y_IMMD = 8'h30,
		OPCODE_ADDW_Y_IMMD = 8'h31,
		OPCODE_INCW_Y = 8'h32,
		OPCODE_CLRW_Y = 8'h33,
		OPCODE_TSTW_Y = 8'h34,
		OPCODE_JR_D = 8'h40,
		OPCODE_JRZ_D = 8'h41,
		OPCODE_JRNZ_D = 8'h42,
		OPCODE_JRC_D = 8'h43,
		OPCODE_JRNC_D = 8'h44,
		OPCODE_JRN_D = 8'h45,
		OPCODE_JRNN_D = 8'h46,
		OPCODE_ALTACC1 = 8'h51,
		OPCODE_ALTACC2 = 8'h52,
		OPCODE_ALTACC3 = 8'h53,
		OPCODE_ALTACC4 = 8'h54,
		OPCODE_ALTACC5 = 8'h55
	} opcode_t;

	// same word, immediate view or displacement view
	typedef union packed
	{
		struct packed
		{
			logic [`F8_WORD_W-1:0] imm;
			opcode_t opcode;
		} imm_form;
		struct packed
		{
			logic [`F8_INST_W-2*`F8_BYTE_W-1:0] unused;
			logic signed [`F8_BYTE_W-1:0] disp;
			opcode_t opcode;
		} rel_form;
	} inst_word_t;

	typedef enum logic [4:0]
	{
		OP_NOP, OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_AND, OP_OR, OP_XOR, OP_CP,
		OP_INC, OP_DEC, OP_CLR, OP_TST, OP_SRL, OP_SLL, OP_RRC, OP_RLC,
		OP_LDW, OP_ADDW, OP_INCW, OP_CLRW, OP_TSTW,
		OP_JUMP, OP_PREFIX
	} alu_op_t;

	// 8-bit accumulator, then 16-bit accumulator
	typedef enum logic [2:0]
	{
		ACCSEL_XL_Y = 3'b000,
		ACCSEL_YL_Z = 3'b010,
		ACCSEL_ZL_X = 3'b011,
		ACCSEL_XH_Y = 3'b101,
		ACCSEL_YH_Z = 3'b110,
		ACCSEL_ZH_Y = 3'b111
	} accsel_t;

	typedef enum logic [1:0]
	{
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_idx_t;

	typedef enum logic [2:0]
	{
		FLAG_H = 3'd0,
		FLAG_C = 3'd1,
		FLAG_N = 3'd2,
		FLAG_Z = 3'd3,
		FLAG_O = 3'd4
	} flag_idx_t;

	typedef enum logic [2:0]
	{
		COND_ALWAYS, COND_Z, COND_NZ, COND_C, COND_NC, COND_N, COND_NN
	} jump_cond_t;

endpackage

/* logic/inst_decode.sv */
`include "f8_exec_config.svh"

module inst_decode
(
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input f8_exec_pkg::inst_word_t inst,
	output logic dec_valid,
	output f8_exec_pkg::alu_op_t dec_op,
	output logic dec_wide,
	output f8_exec_pkg::reg_idx_t dec_reg,
	output logic [1:0] dec_mask,
	output logic dec_byte_hi,
	output logic [`F8_WORD_W-1:0] dec_imm,
	output f8_exec_pkg::jump_cond_t dec_cond,
	output logic [1:0] dec_size
);
	import f8_exec_pkg::*;

	accsel_t accsel;
	accsel_t next_accsel;
	alu_op_t op;
	jump_cond_t cond;
	logic wide;
	logic [1:0] size;
	logic byte_hi;
	reg_idx_t acc8_reg;
	reg_idx_t acc16_reg;
	logic [`F8_WORD_W-1:0] imm;

	always_comb
	begin
		case (inst.imm_form.opcode)
			OPCODE_ADD_XL_IMMD: op = OP_ADD;
			OPCODE_ADC_XL_IMMD: op = OP_ADC;
			OPCODE_SUB_XL_IMMD: op = OP_SUB;
			OPCODE_SBC_XL_IMMD: op = OP_SBC;
			OPCODE_AND_XL_IMMD: op = OP_AND;
			OPCODE_OR_XL_IMMD: op = OP_OR;
			OPCODE_XOR_XL_IMMD: op = OP_XOR;
			OPCODE_CP_XL_IMMD: op = OP_CP;
			OPCODE_INC_XL: op = OP_INC;
			OPCODE_DEC_XL: op = OP_DEC;
			OPCODE_CLR_XL: op = OP_CLR;
			OPCODE_TST_XL: op = OP_TST;
			OPCODE_SRL_XL: op = OP_SRL;
			OPCODE_SLL_XL: op = OP_SLL;
			OPCODE_RRC_XL: op = OP_RRC;
			OPCODE_RLC_XL: op = OP_RLC;
			OPCODE_LDW_Y_IMMD: op = OP_LDW;
			OPCODE_ADDW_Y_IMMD: op = OP_ADDW;
			OPCODE_INCW_Y: op = OP_INCW;
			OPCODE_CLRW_Y: op = OP_CLRW;
			OPCODE_TSTW_Y: op = OP_TSTW;
			OPCODE_JR_D, OPCODE_JRZ_D, OPCODE_JRNZ_D, OPCODE_JRC_D,
			OPCODE_JRNC_D, OPCODE_JRN_D, OPCODE_JRNN_D: op = OP_JUMP;
			OPCODE_ALTACC1, OPCODE_ALTACC2, OPCODE_ALTACC3,
			OPCODE_ALTACC4, OPCODE_ALTACC5: op = OP_PREFIX;
			// unknown opcodes behave as nop
			default: op = OP_NOP;
		endcase

		case (inst.imm_form.opcode)
			OPCODE_JRZ_D: cond = COND_Z;
			OPCODE_JRNZ_D: cond = COND_NZ;
			OPCODE_JRC_D: cond = COND_C;
			OPCODE_JRNC_D: cond = COND_NC;
			OPCODE_JRN_D: cond = COND_N;
			OPCODE_JRNN_D: cond = COND_NN;
			default: cond = COND_ALWAYS;
		endcase

		// any non-prefix drops back to the default selection
		case (inst.imm_form.opcode)
			OPCODE_ALTACC1: next_accsel = ACCSEL_XH_Y;
			OPCODE_ALTACC2: next_accsel = ACCSEL_YL_Z;
			OPCODE_ALTACC3: next_accsel = ACCSEL_ZL_X;
			OPCODE_ALTACC4: next_accsel = ACCSEL_YH_Z;
			OPCODE_ALTACC5: next_accsel = ACCSEL_ZH_Y;
			default: next_accsel = ACCSEL_XL_Y;
		endcase

		case (op)
			OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_AND, OP_OR, OP_XOR, OP_CP,
			OP_JUMP: size = 2'd2;
			OP_LDW, OP_ADDW: size = 2'd3;
			default: size = 2'd1;
		endcase
	end

	assign wide = op inside {OP_LDW, OP_ADDW, OP_INCW, OP_CLRW, OP_TSTW};
	assign byte_hi = accsel inside {ACCSEL_XH_Y, ACCSEL_YH_Z, ACCSEL_ZH_Y};

	always_comb
	begin
		case (accsel)
			ACCSEL_YL_Z, ACCSEL_YH_Z: acc8_reg = REG_Y;
			ACCSEL_ZL_X, ACCSEL_ZH_Y: acc8_reg = REG_Z;
			default: acc8_reg = REG_X;
		endcase
		case (accsel)
			ACCSEL_YL_Z, ACCSEL_YH_Z: acc16_reg = REG_Z;
			ACCSEL_ZL_X: acc16_reg = REG_X;
			default: acc16_reg = REG_Y;
		endcase
	end

	// jumps carry a sign-extended displacement
	assign imm = (op == OP_JUMP) ?
		{{(`F8_WORD_W-`F8_BYTE_W){inst.rel_form.disp[`F8_BYTE_W-1]}}, inst.rel_form.disp} :
		inst.imm_form.imm;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dec_valid <= 1'b0;
			accsel <= ACCSEL_XL_Y;
		end
		else
		begin
			dec_valid <= inst_valid;
			if (inst_valid)
				accsel <= next_accsel;
		end
	end

	always_ff @(posedge clk)
	begin
		if (inst_valid)
		begin
			dec_op <= op;
			dec_wide <= wide;
			dec_reg <= wide ? acc16_reg : acc8_reg;
			dec_mask <= wide ? 2'b11 : (byte_hi ? 2'b10 : 2'b01);
			dec_byte_hi <= byte_hi;
			dec_imm <= imm;
			dec_cond <= cond;
			dec_size <= size;
		end
	end

endmodule

/* logic/alu_execute.sv */
`include "f8_exec_config.svh"

module alu_execute
(
	input logic dec_valid,
	input f8_exec_pkg::alu_op_t dec_op,
	input logic dec_wide,
	input f8_exec_pkg::reg_idx_t dec_reg,
	input logic [1:0] dec_mask,
	input logic dec_byte_hi,
	input logic [`F8_WORD_W-1:0] dec_imm,
	input f8_exec_pkg::jump_cond_t dec_cond,
	input logic [1:0] dec_size,
	input logic [`F8_WORD_W-1:0] x,
	input logic [`F8_WORD_W-1:0] y,
	input logic [`F8_WORD_W-1:0] z,
	input logic [`F8_FLAG_W-1:0] flags,
	input logic [`F8_WORD_W-1:0] pc,
	output logic ex_valid,
	output f8_exec_pkg::reg_idx_t ex_reg,
	output logic [1:0] ex_mask,
	output logic [`F8_WORD_W-1:0] ex_data,
	output logic [`F8_FLAG_W-1:0] ex_flags,
	output logic [`F8_WORD_W-1:0] ex_pc
);
	import f8_exec_pkg::*;

	logic [`F8_WORD_W-1:0] acc16;
	logic [`F8_BYTE_W-1:0] acc8;
	logic [`F8_BYTE_W-1:0] imm8;
	logic [`F8_WORD_W-1:0] add_a;
	logic [`F8_WORD_W-1:0] add_b;
	logic add_cin;
	logic [4:0] sum_h;
	logic [`F8_BYTE_W:0] sum8;
	logic [`F8_WORD_W:0] sum16;
	logic [`F8_BYTE_W-1:0] res8;
	logic [`F8_WORD_W-1:0] res16;
	logic taken;

	// dec_reg already names the accumulator register
	always_comb
	begin
		case (dec_reg)
			REG_Y: acc16 = y;
			REG_Z: acc16 = z;
			default: acc16 = x;
		endcase
	end

	assign acc8 = dec_byte_hi ? acc16[`F8_WORD_W-1:`F8_BYTE_W] : acc16[`F8_BYTE_W-1:0];
	assign imm8 = dec_imm[`F8_BYTE_W-1:0];

	// subtraction is a plus ~b plus 1 (or plus C), no borrow inversion
	always_comb
	begin
		add_a = dec_wide ? acc16 : {8'h00, acc8};
		case (dec_op)
			OP_ADD, OP_ADC: add_b = {8'h00, imm8};
			OP_SUB, OP_SBC, OP_CP: add_b = {8'h00, ~imm8};
			OP_INC, OP_INCW: add_b = 16'h0001;
			OP_DEC: add_b = 16'h00ff;
			OP_ADDW: add_b = dec_imm;
			default: add_b = '0;
		endcase
		case (dec_op)
			OP_ADC, OP_SBC: add_cin = flags[FLAG_C];
			OP_SUB, OP_CP: add_cin = 1'b1;
			default: add_cin = 1'b0;
		endcase
	end

	assign sum_h = {1'b0, add_a[3:0]} + {1'b0, add_b[3:0]} + {4'd0, add_cin};
	assign sum8 = {1'b0, add_a[`F8_BYTE_W-1:0]} + {1'b0, add_b[`F8_BYTE_W-1:0]} +
		{{`F8_BYTE_W{1'b0}}, add_cin};
	assign sum16 = {1'b0, add_a} + {1'b0, add_b} + {{`F8_WORD_W{1'b0}}, add_cin};

	always_comb
	begin
		res8 = sum8[`F8_BYTE_W-1:0];
		res16 = sum16[`F8_WORD_W-1:0];
		ex_flags = flags;
		case (dec_op)
			OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP, OP_INC, OP_DEC:
			begin
				ex_flags[FLAG_H] = sum_h[4];
				ex_flags[FLAG_C] = sum8[`F8_BYTE_W];
				ex_flags[FLAG_O] = (add_a[7] == add_b[7]) && (res8[7] != add_a[7]);
			end
			// word forms leave H alone
			OP_ADDW, OP_INCW:
			begin
				ex_flags[FLAG_C] = sum16[`F8_WORD_W];
				ex_flags[FLAG_O] = (add_a[15] == add_b[15]) && (res16[15] != add_a[15]);
			end
			OP_AND: res8 = acc8 & imm8;
			OP_OR: res8 = acc8 | imm8;
			OP_XOR: res8 = acc8 ^ imm8;
			OP_SRL:
			begin
				res8 = {1'b0, acc8[7:1]};
				ex_flags[FLAG_C] = acc8[0];
			end
			OP_SLL:
			begin
				res8 = {acc8[6:0], 1'b0};
				ex_flags[FLAG_C] = acc8[7];
			end
			OP_RRC:
			begin
				res8 = {flags[FLAG_C], acc8[7:1]};
				ex_flags[FLAG_C] = acc8[0];
			end
			OP_RLC:
			begin
				res8 = {acc8[6:0], flags[FLAG_C]};
				ex_flags[FLAG_C] = acc8[7];
			end
			OP_CLR: res8 = '0;
			OP_CLRW: res16 = '0;
			OP_TST:
			begin
				res8 = acc8;
				ex_flags[FLAG_O] = ^acc8;
				ex_flags[FLAG_C] = 1'b0;
			end
			OP_TSTW:
			begin
				res16 = acc16;
				ex_flags[FLAG_O] = ^acc16;
				ex_flags[FLAG_C] = 1'b1;
			end
			OP_LDW: res16 = dec_imm;
			default: ex_flags = flags;
		endcase

		if (!(dec_op inside {OP_CLR, OP_CLRW, OP_JUMP, OP_PREFIX, OP_NOP}))
		begin
			ex_flags[FLAG_Z] = dec_wide ? (res16 == '0) : (res8 == '0);
			ex_flags[FLAG_N] = dec_wide ? res16[`F8_WORD_W-1] : res8[`F8_BYTE_W-1];
		end
	end

	always_comb
	begin
		case (dec_cond)
			COND_Z: taken = flags[FLAG_Z];
			COND_NZ: taken = !flags[FLAG_Z];
			COND_C: taken = flags[FLAG_C];
			COND_NC: taken = !flags[FLAG_C];
			COND_N: taken = flags[FLAG_N];
			COND_NN: taken = !flags[FLAG_N];
			default: taken = 1'b1;
		endcase
	end

	assign ex_valid = dec_valid;
	assign ex_reg = dec_reg;
	assign ex_data = dec_wide ? res16 : {res8, res8};
	assign ex_mask = (dec_op inside {OP_CP, OP_TST, OP_TSTW, OP_JUMP, OP_PREFIX, OP_NOP}) ?
		2'b00 : dec_mask;

	// taken jumps are relative to the jump's own address
	assign ex_pc = (dec_op == OP_JUMP && taken) ? pc + dec_imm :
		pc + {{(`F8_WORD_W-2){1'b0}}, dec_size};

endmodule

/* logic/reg_writeback.sv */
`include "f8_exec_config.svh"

module reg_writeback
(
	input logic clk,
	input logic reset,
	input logic ex_valid,
	input f8_exec_pkg::reg_idx_t ex_reg,
	input logic [1:0] ex_mask,
	input logic [`F8_WORD_W-1:0] ex_data,
	input logic [`F8_FLAG_W-1:0] ex_flags,
	input logic [`F8_WORD_W-1:0] ex_pc,
	output logic [`F8_WORD_W-1:0] x,
	output logic [`F8_WORD_W-1:0] y,
	output logic [`F8_WORD_W-1:0] z,
	output logic [`F8_FLAG_W-1:0] flags,
	output logic [`F8_WORD_W-1:0] pc,
	output logic retire,
	output f8_exec_pkg::reg_idx_t wb_reg,
	output logic [1:0] wb_mask,
	output logic [`F8_WORD_W-1:0] wb_data
);
	import f8_exec_pkg::*;

	logic [`F8_WORD_W-1:0] regs [`F8_NUM_REGS];

	assign x = regs[REG_X];
	assign y = regs[REG_Y];
	assign z = regs[REG_Z];

	// byte lanes written separately
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `F8_NUM_REGS; i++)
				regs[i] <= '0;
			flags <= '0;
			pc <= `F8_RESET_PC;
		end
		else if (ex_valid)
		begin
			if (ex_mask[0])
				regs[ex_reg][`F8_BYTE_W-1:0] <= ex_data[`F8_BYTE_W-1:0];
			if (ex_mask[1])
				regs[ex_reg][`F8_WORD_W-1:`F8_BYTE_W] <= ex_data[`F8_WORD_W-1:`F8_BYTE_W];
			flags <= ex_flags;
			pc <= ex_pc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			retire <= 1'b0;
		else
			retire <= ex_valid;
	end

	// write record, qualified by retire
	always_ff @(posedge clk)
	begin
		if (ex_valid)
		begin
			wb_reg <= ex_reg;
			wb_mask <= ex_mask;
			wb_data <= ex_data;
		end
	end

endmodule

/* logic/f8_exec_top.sv */
`include "f8_exec_config.svh"

module f8_exec_top
(
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input f8_exec_pkg::inst_word_t inst,
	output logic retire,
	output f8_exec_pkg::reg_idx_t wb_reg,
	output logic [1:0] wb_mask,
	output logic [`F8_WORD_W-1:0] wb_data,
	output logic [`F8_FLAG_W-1:0] flags,
	output logic [`F8_WORD_W-1:0] pc
);
	import f8_exec_pkg::*;

	// decode to execute
	logic dec_valid;
	alu_op_t dec_op;
	logic dec_wide;
	reg_idx_t dec_reg;
	logic [1:0] dec_mask;
	logic dec_byte_hi;
	logic [`F8_WORD_W-1:0] dec_imm;
	jump_cond_t dec_cond;
	logic [1:0] dec_size;

	// execute to writeback
	logic ex_valid;
	reg_idx_t ex_reg;
	logic [1:0] ex_mask;
	logic [`F8_WORD_W-1:0] ex_data;
	logic [`F8_FLAG_W-1:0] ex_flags;
	logic [`F8_WORD_W-1:0] ex_pc;

	// architectural registers
	logic [`F8_WORD_W-1:0] x;
	logic [`F8_WORD_W-1:0] y;
	logic [`F8_WORD_W-1:0] z;

	inst_decode u_decode (.*);

	alu_execute u_execute (.*);

	reg_writeback u_writeback (.*);

endmodule

/* test/f8_exec_checker.sv */
`include "f8_exec_config.svh"

module f8_exec_checker
(
	input logic clk,
	input logic reset,
	input logic exp_push,
	input logic [8*12-1:0] exp_name,
	input logic [1:0] exp_reg,
	input logic [1:0] exp_mask,
	input logic [`F8_WORD_W-1:0] exp_data,
	input logic [`F8_FLAG_W-1:0] exp_flags,
	input logic [`F8_WORD_W-1:0] exp_pc,
	input logic retire,
	input f8_exec_pkg::reg_idx_t wb_reg,
	input logic [1:0] wb_mask,
	input logic [`F8_WORD_W-1:0] wb_data,
	input logic [`F8_FLAG_W-1:0] flags,
	input logic [`F8_WORD_W-1:0] pc,
	output int checked_count,
	output int pass_count,
	output int error_count
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [8*12-1:0] q_name [$];
	logic [1:0] q_reg [$];
	logic [1:0] q_mask [$];
	logic [`F8_WORD_W-1:0] q_data [$];
	logic [`F8_FLAG_W-1:0] q_flags [$];
	logic [`F8_WORD_W-1:0] q_pc [$];

	initial
	begin
		checked_count = 0;
		pass_count = 0;
		error_count = 0;
	end

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		logic [8*12-1:0] name;
		logic [1:0] e_reg;
		logic [1:0] e_mask;
		logic [`F8_WORD_W-1:0] e_data;
		logic [`F8_FLAG_W-1:0] e_flags;
		logic [`F8_WORD_W-1:0] e_pc;
		logic ok;
		if (exp_push)
		begin
			q_name.push_back(exp_name);
			q_reg.push_back(exp_reg);
			q_mask.push_back(exp_mask);
			q_data.push_back(exp_data);
			q_flags.push_back(exp_flags);
			q_pc.push_back(exp_pc);
		end
		if (!reset && retire)
		begin
			if (q_name.size() == 0)
			begin
				$display("an instruction retired with no test left to match it");
				error_count++;
			end
			else
			begin
				name = q_name.pop_front();
				e_reg = q_reg.pop_front();
				e_mask = q_mask.pop_front();
				e_data = q_data.pop_front();
				e_flags = q_flags.pop_front();
				e_pc = q_pc.pop_front();
				ok = 1'b1;
				if (wb_mask !== e_mask)
				begin
					$display("[ERROR] %0s wb_mask expected %b actual %b", name, e_mask, wb_mask);
					ok = 1'b0;
				end
				else if (e_mask != 2'b00 && wb_reg !== e_reg)
				begin
					$display("[ERROR] %0s wb_reg expected %0d actual %0d", name, e_reg, wb_reg);
					ok = 1'b0;
				end
				if (e_mask != 2'b00 && wb_data !== e_data)
				begin
					$display("[ERROR] %0s wb_data expected %h actual %h", name, e_data, wb_data);
					ok = 1'b0;
				end
				if (flags !== e_flags)
				begin
					$display("[ERROR] %0s flags expected %b actual %b", name, e_flags, flags);
					ok = 1'b0;
				end
				if (pc !== e_pc)
				begin
					$display("[ERROR] %0s pc expected %h actual %h", name, e_pc, pc);
					ok = 1'b0;
				end
				if (ok)
				begin
					$display("[PASS] %0s", name);
					pass_count++;
				end
				else
					error_count++;
				checked_count++;
			end
		end
	end

endmodule

/* test/f8_exec_tb.sv */
`include "f8_exec_config.svh"

module f8_exec_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import f8_exec_pkg::*;

	logic clk;
	logic reset;
	logic inst_valid;
	inst_word_t inst;
	logic retire;
	reg_idx_t wb_reg;
	logic [1:0] wb_mask;
	logic [`F8_WORD_W-1:0] wb_data;
	logic [`F8_FLAG_W-1:0] flags;
	logic [`F8_WORD_W-1:0] pc;

	logic exp_push;
	logic [8*12-1:0] exp_name;
	logic [1:0] exp_reg;
	logic [1:0] exp_mask;
	logic [`F8_WORD_W-1:0] exp_data;
	logic [`F8_FLAG_W-1:0] exp_flags;
	logic [`F8_WORD_W-1:0] exp_pc;
	int checked_count;
	int pass_count;
	int error_count;

	// stimulus and expectation table
	logic [8*12-1:0] row_name [$];
	logic [`F8_INST_W-1:0] row_inst [$];
	logic [1:0] row_reg [$];
	logic [1:0] row_mask [$];
	logic [`F8_WORD_W-1:0] row_data [$];
	logic [`F8_FLAG_W-1:0] row_flags [$];
	logic [`F8_WORD_W-1:0] row_pc [$];
	logic row_chain [$];

	logic [31:0] lfsr;

	f8_exec_top u_f8_exec_top (.*);

	f8_exec_checker u_checker (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int idle_cycles();
		int n;
		lfsr = lfsr_step(lfsr);
		n = lfsr[0];
		lfsr = lfsr_step(lfsr);
		n = n + 2 * lfsr[0];
		return n;
	endfunction

	task automatic add_row(input logic [8*12-1:0] name, input logic [23:0] word,
		input logic [1:0] r, input logic [1:0] m, input logic [15:0] d,
		input logic [4:0] f, input logic [15:0] p, input logic chain);
		row_name.push_back(name);
		row_inst.push_back(word);
		row_reg.push_back(r);
		row_mask.push_back(m);
		row_data.push_back(d);
		row_flags.push_back(f);
		row_pc.push_back(p);
		row_chain.push_back(chain);
	endtask

	// flags are O Z N C H
	task automatic build_table();
		add_row("ldw_y_neg", 24'h800130, 2'd1, 2'd3, 16'h8001, 5'b00100, 16'h4003, 1'b0);
		add_row("addw_carry", 24'h7fff31, 2'd1, 2'd3, 16'h0000, 5'b01010, 16'h4006, 1'b0);
		add_row("ldw_y_7fff", 24'h7fff30, 2'd1, 2'd3, 16'h7fff, 5'b00010, 16'h4009, 1'b0);
		add_row("incw_ovf", 24'h000032, 2'd1, 2'd3, 16'h8000, 5'b10100, 16'h400a, 1'b0);
		add_row("ldw_y_ffff", 24'hffff30, 2'd1, 2'd3, 16'hffff, 5'b10100, 16'h400d, 1'b0);
		add_row("incw_wrap", 24'h000032, 2'd1, 2'd3, 16'h0000, 5'b01010, 16'h400e, 1'b0);
		add_row("add_xl", 24'h003510, 2'd0, 2'd1, 16'h3535, 5'b00000, 16'h4010, 1'b0);
		add_row("adc_carry", 24'h00cb11, 2'd0, 2'd1, 16'h0000, 5'b01011, 16'h4012, 1'b0);
		add_row("adc_cin_ovf", 24'h007f11, 2'd0, 2'd1, 16'h8080, 5'b10101, 16'h4014, 1'b0);
		add_row("sub_ovf", 24'h000112, 2'd0, 2'd1, 16'h7f7f, 5'b10010, 16'h4016, 1'b0);
		add_row("sbc_cin", 24'h001013, 2'd0, 2'd1, 16'h6f6f, 5'b00011, 16'h4018, 1'b0);
		add_row("and_xl", 24'h000f14, 2'd0, 2'd1, 16'h0f0f, 5'b00011, 16'h401a, 1'b0);
		add_row("or_xl", 24'h00f015, 2'd0, 2'd1, 16'hffff, 5'b00111, 16'h401c, 1'b0);
		add_row("xor_xl", 24'h00ff16, 2'd0, 2'd1, 16'h0000, 5'b01011, 16'h401e, 1'b0);
		add_row("cp_xl", 24'h000117, 2'd0, 2'd0, 16'h0000, 5'b00100, 16'h4020, 1'b0);
		add_row("dec_xl", 24'h000021, 2'd0, 2'd1, 16'hffff, 5'b00100, 16'h4021, 1'b0);
		add_row("inc_wrap", 24'h000020, 2'd0, 2'd1, 16'h0000, 5'b01011, 16'h4022, 1'b0);
		add_row("inc_xl", 24'h000020, 2'd0, 2'd1, 16'h0101, 5'b00000, 16'h4023, 1'b0);
		add_row("srl_cout", 24'h000024, 2'd0, 2'd1, 16'h0000, 5'b01010, 16'h4024, 1'b0);
		add_row("rrc_cin", 24'h000026, 2'd0, 2'd1, 16'h8080, 5'b00100, 16'h4025, 1'b0);
		add_row("sll_cout", 24'h000025, 2'd0, 2'd1, 16'h0000, 5'b01010, 16'h4026, 1'b0);
		add_row("rlc_cin", 24'h000027, 2'd0, 2'd1, 16'h0101, 5'b00000, 16'h4027, 1'b0);
		add_row("rlc_xl", 24'h000027, 2'd0, 2'd1, 16'h0202, 5'b00000, 16'h4028, 1'b0);
		add_row("tst_parity", 24'h000023, 2'd0, 2'd0, 16'h0000, 5'b10000, 16'h4029, 1'b0);
		add_row("clr_xl", 24'h000022, 2'd0, 2'd1, 16'h0000, 5'b10000, 16'h402a, 1'b0);
		add_row("tst_zero", 24'h000023, 2'd0, 2'd0, 16'h0000, 5'b01000, 16'h402b, 1'b0);
		add_row("altacc1", 24'h000051, 2'd0, 2'd0, 16'h0000, 5'b01000, 16'h402c, 1'b0);
		add_row("add_xh", 24'h001210, 2'd0, 2'd2, 16'h1212, 5'b00000, 16'h402e, 1'b0);
		add_row("inc_back_xl", 24'h000020, 2'd0, 2'd1, 16'h0101, 5'b00000, 16'h402f, 1'b0);
		add_row("altacc2", 24'h000052, 2'd0, 2'd0, 16'h0000, 5'b00000, 16'h4030, 1'b0);
		add_row("ldw_z", 24'h123430, 2'd2, 2'd3, 16'h1234, 5'b00000, 16'h4033, 1'b0);
		add_row("altacc2_b", 24'h000052, 2'd0, 2'd0, 16'h0000, 5'b00000, 16'h4034, 1'b0);
		add_row("inc_yl", 24'h000020, 2'd1, 2'd1, 16'h0101, 5'b00000, 16'h4035, 1'b0);
		add_row("altacc3", 24'h000053, 2'd0, 2'd0, 16'h0000, 5'b00000, 16'h4036, 1'b0);
		add_row("incw_x", 24'h000032, 2'd0, 2'd3, 16'h1202, 5'b00000, 16'h4037, 1'b0);
		add_row("altacc3_b", 24'h000053, 2'd0, 2'd0, 16'h0000, 5'b00000, 16'h4038, 1'b0);
		add_row("dec_zl", 24'h000021, 2'd2, 2'd1, 16'h3333, 5'b00011, 16'h4039, 1'b0);
		add_row("altacc4", 24'h000054, 2'd0, 2'd0, 16'h0000, 5'b00011, 16'h403a, 1'b0);
		add_row("or_yh", 24'h008015, 2'd1, 2'd2, 16'h8080, 5'b00111, 16'h403c, 1'b0);
		add_row("altacc5", 24'h000055, 2'd0, 2'd0, 16'h0000, 5'b00111, 16'h403d, 1'b0);
		add_row("sll_zh", 24'h000025, 2'd2, 2'd2, 16'h2424, 5'b00001, 16'h403e, 1'b0);
		add_row("altacc4_b", 24'h000054, 2'd0, 2'd0, 16'h0000, 5'b00001, 16'h403f, 1'b0);
		add_row("tstw_z", 24'h000034, 2'd0, 2'd0, 16'h0000, 5'b00011, 16'h4040, 1'b0);
		add_row("clrw_y", 24'h000033, 2'd1, 2'd3, 16'h0000, 5'b00011, 16'h4041, 1'b0);
		add_row("jrz_not", 24'h001041, 2'd0, 2'd0, 16'h0000, 5'b00011, 16'h4043, 1'b0);
		add_row("jrnz_taken", 24'h001042, 2'd0, 2'd0, 16'h0000, 5'b00011, 16'h4053, 1'b0);
		add_row("jrc_back", 24'h00fc43, 2'd0, 2'd0, 16'h0000, 5'b00011, 16'h404f, 1'b0);
		add_row("jrnc_not", 24'h000544, 2'd0, 2'd0, 16'h0000, 5'b00011, 16'h4051, 1'b0);
		add_row("jrn_not", 24'h000545, 2'd0, 2'd0, 16'h0000, 5'b00011, 16'h4053, 1'b0);
		add_row("jrnn_back", 24'h00e046, 2'd0, 2'd0, 16'h0000, 5'b00011, 16'h4033, 1'b0);
		add_row("xor_to_zero", 24'h000216, 2'd0, 2'd1, 16'h0000, 5'b01011, 16'h4035, 1'b0);
		add_row("jrz_back", 24'h00cb41, 2'd0, 2'd0, 16'h0000, 5'b01011, 16'h4000, 1'b0);
		add_row("jrnz_not", 24'h000742, 2'd0, 2'd0, 16'h0000, 5'b01011, 16'h4002, 1'b0);
		add_row("dec_neg", 24'h000021, 2'd0, 2'd1, 16'hffff, 5'b00100, 16'h4003, 1'b0);
		add_row("jrn_taken", 24'h004045, 2'd0, 2'd0, 16'h0000, 5'b00100, 16'h4043, 1'b0);
		add_row("jrnn_not", 24'h000146, 2'd0, 2'd0, 16'h0000, 5'b00100, 16'h4045, 1'b0);
		add_row("jrc_not", 24'h000143, 2'd0, 2'd0, 16'h0000, 5'b00100, 16'h4047, 1'b0);
		add_row("jrnc_back", 24'h008044, 2'd0, 2'd0, 16'h0000, 5'b00100, 16'h3fc7, 1'b0);
		// dependent chain, no idle cycles
		add_row("ldw_chain", 24'h00ff30, 2'd1, 2'd3, 16'h00ff, 5'b00000, 16'h3fca, 1'b0);
		add_row("addw_chain", 24'h000131, 2'd1, 2'd3, 16'h0100, 5'b00000, 16'h3fcd, 1'b1);
		add_row("incw_chain", 24'h000032, 2'd1, 2'd3, 16'h0101, 5'b00000, 16'h3fce, 1'b1);
		add_row("add_chain", 24'h000110, 2'd0, 2'd1, 16'h0000, 5'b01011, 16'h3fd0, 1'b1);
		add_row("tst_c_clear", 24'h000023, 2'd0, 2'd0, 16'h0000, 5'b01001, 16'h3fd1, 1'b0);
		add_row("inc_to_odd", 24'h000020, 2'd0, 2'd1, 16'h0101, 5'b00000, 16'h3fd2, 1'b0);
		add_row("rrc_cout", 24'h000026, 2'd0, 2'd1, 16'h0000, 5'b01010, 16'h3fd3, 1'b0);
		add_row("jr_fwd", 24'h001040, 2'd0, 2'd0, 16'h0000, 5'b01010, 16'h3fe3, 1'b0);
	endtask

	initial
	begin
		int gap;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		exp_push = 1'b0;
		exp_name = '0;
		exp_reg = '0;
		exp_mask = '0;
		exp_data = '0;
		exp_flags = '0;
		exp_pc = '0;
		lfsr = 32'h9bc70d33;
		build_table();
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		for (int i = 0; i < row_name.size(); i++)
		begin
			if (i > 0 && !row_chain[i])
			begin
				gap = idle_cycles();
				repeat (gap)
				begin
					@(posedge clk);
					#1;
				end
			end
			inst_valid = 1'b1;
			inst = row_inst[i];
			exp_push = 1'b1;
			exp_name = row_name[i];
			exp_reg = row_reg[i];
			exp_mask = row_mask[i];
			exp_data = row_data[i];
			exp_flags = row_flags[i];
			exp_pc = row_pc[i];
			@(posedge clk);
			#1;
			inst_valid = 1'b0;
			exp_push = 1'b0;
		end
		while (checked_count < row_name.size())
			@(posedge clk);
		// room for any stray retire
		repeat (4) @(posedge clk);
		$display("tests: %0d, passed: %0d, failed: %0d", row_name.size(), pass_count,
			row_name.size() - pass_count);
		if (error_count == 0 && pass_count == row_name.size())
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		#1;
		repeat (row_name.size() * 5 + 20) @(posedge clk);
		$display("timeout: only %0d of %0d instructions retired", checked_count,
			row_name.size());
		$display("tests failed");
		$finish;
	end

endmodule

/* f8_exec.f */
+incdir+include
logic/f8_exec_pkg.sv
logic/inst_decode.sv
logic/alu_execute.sv
logic/reg_writeback.sv
logic/f8_exec_top.sv
test/f8_exec_checker.sv
test/f8_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the f8_exec testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f f8_exec.f --top-module f8_exec_tb \
	-Mdir obj_dir -o f8_exec_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/f8_exec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
	exit 0
fi
exit 1
